//--- mipsExecCore.f
hw/mipsPkg.sv
hw/alu.sv
hw/instrDecode.sv
hw/regFile.sv
hw/execStage.sv
hw/mipsExecCore.sv
verification/tbMipsExecCore.sv

//--- Makefile
TOP = tbMipsExecCore

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f mipsExecCore.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

//--- verification/tbMipsExecCore.sv
// Directed testbench for the execute core that checks every result against a reference model
`timescale 1ns/1ps

module tbMipsExecCore
    import mipsPkg::*;
();

    typedef struct packed {
        aluFuncT               func;
        logic [31:0]           result;
        logic [3:0]            flags;     // carry, zero, overflow, negative
        logic [REG_ADDR_W-1:0] dest;
        logic                  write;
        logic                  trap;
        logic                  illegal;
        logic                  checkValue;
    } expectT;

    logic                  clk;
    logic                  rst;
    logic                  instrValid;
    logic [31:0]           instr;
    logic                  loadValid;
    logic [REG_ADDR_W-1:0] loadAddr;
    logic [31:0]           loadData;
    logic                  resultValid;
    logic [31:0]           result;
    logic                  carry;
    logic                  zero;
    logic                  overflow;
    logic                  negative;
    logic                  regWrite;
    logic [REG_ADDR_W-1:0] writeAddr;
    logic                  trap;
    logic                  illegal;

    logic [31:0] model [32];   // Architectural register state
    expectT      pending[$];   // Issued, not yet reported
    int          errorCount = 0;
    int          checkCount = 0;
    int          stepCount  = 0;   // Driven cycles for the watchdog budget
    int          seed       = 32'hd067;

    mipsExecCore i_mipsExecCore (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .loadValid   (loadValid),
        .loadAddr    (loadAddr),
        .loadData    (loadData),
        .resultValid (resultValid),
        .result      (result),
        .carry       (carry),
        .zero        (zero),
        .overflow    (overflow),
        .negative    (negative),
        .regWrite    (regWrite),
        .writeAddr   (writeAddr),
        .trap        (trap),
        .illegal     (illegal)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------
    // Compare tasks
    task automatic checkWord(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERROR @ %0t: %s is %08h, expected %08h", $time, what, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkFlags(input aluFuncT f, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp)
        begin
            $display("ERROR @ %0t: %s flags cznv=%b, expected %b", $time, f.name(), got, exp);
            errorCount++;
        end
    endtask

    // Status is {regWrite, trap, illegal}
    task automatic checkFunc(input aluFuncT f, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp)
        begin
            $display("ERROR @ %0t: %s (%02h) write/trap/illegal=%b, expected %b",
                     $time, f.name(), 6'(f), got, exp);
            errorCount++;
        end
    endtask

    // --------------------
    // Reference model
    function automatic expectT predict(input aluFuncT f, input logic [31:0] a,
                                       input logic [31:0] b, input logic [REG_ADDR_W-1:0] sa,
                                       input logic [REG_ADDR_W-1:0] dest);
        logic [31:0] res;
        logic        c;
        logic        v;
        longint      wide;
        expectT      e;
        c = 1'b0;
        v = 1'b0;
        case (f)
            ADD, ADDU:
            begin
                res  = a + b;
                c    = (res < a);   // Unsigned wrap
                wide = longint'($signed(a)) + longint'($signed(b));
                v    = (f == ADD) ? (wide != longint'($signed(res))) : c;
            end
            SUB, SUBU:
            begin
                res  = a - b;
                c    = (a < b);     // Borrow
                wide = longint'($signed(a)) - longint'($signed(b));
                v    = (f == SUB) ? (wide != longint'($signed(res))) : c;
            end
            SLL:  res = b << sa;
            SRL:  res = b >> sa;
            SRA:  res = $signed(b) >>> sa;
            SLLV: res = b << a[4:0];
            SRLV: res = b >> a[4:0];
            SRAV: res = $signed(b) >>> a[4:0];
            AND:  res = a & b;
            OR:   res = a | b;
            XOR:  res = a ^ b;
            NOR:  res = ~(a | b);
            SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU: res = (a < b) ? 32'd1 : 32'd0;
            MOVZ, MOVN: res = a;
            default: res = '0;
        endcase
        e.func       = f;
        e.result     = res;
        e.flags      = {c, (res == '0), v, res[31]};
        e.dest       = dest;
        e.trap       = ((f == ADD) || (f == SUB)) && v;
        e.write      = (dest != '0) && !e.trap &&
                       !((f == MOVZ) && (b != '0)) && !((f == MOVN) && (b == '0));
        e.illegal    = 1'b0;
        e.checkValue = 1'b1;
        return e;
    endfunction

    function automatic logic [REG_ADDR_W-1:0] pickReg(input int base, input int span);
        int k;
        k = $unsigned($random(seed)) % span;
        return REG_ADDR_W'(base + k);
    endfunction

    // --------------------
    // Drivers
    task automatic loadReg(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        instrValid = 1'b0;
        loadValid  = 1'b1;
        loadAddr   = addr;
        loadData   = data;
        stepCount++;
        if (addr != '0)
            model[addr] = data;
    endtask

    task automatic sendInstr(input logic [31:0] word, input expectT e);
        @(negedge clk);
        loadValid  = 1'b0;
        instrValid = 1'b1;
        instr      = word;
        stepCount++;
        pending.push_back(e);
        if (e.write)
            model[e.dest] = e.result;   // Updated in program order like the bypass
    endtask

    task automatic issueR(input aluFuncT f, input logic [REG_ADDR_W-1:0] rs,
                          input logic [REG_ADDR_W-1:0] rt, input logic [REG_ADDR_W-1:0] rd,
                          input logic [REG_ADDR_W-1:0] sa);
        sendInstr({SPECIAL, rs, rt, rd, sa, f}, predict(f, model[rs], model[rt], sa, rd));
    endtask

    task automatic issueI(input opcodeT op, input logic [REG_ADDR_W-1:0] rs,
                          input logic [REG_ADDR_W-1:0] rt, input logic [15:0] imm);
        aluFuncT               f;
        logic [31:0]           b;
        logic [REG_ADDR_W-1:0] sa;
        b  = {{16{imm[15]}}, imm};
        sa = '0;
        case (op)
            ADDI:  f = ADD;
            ADDIU: f = ADDU;
            SLTI:  f = SLT;
            SLTIU: f = SLTU;
            ANDI:  f = AND;
            ORI:   f = OR;
            XORI:  f = XOR;
            default:   // LUI
            begin
                f  = SLL;
                sa = 5'd16;
            end
        endcase
        if (op inside {ANDI, ORI, XORI, LUI})
            b = {16'b0, imm};
        sendInstr({op, rs, rt, imm}, predict(f, model[rs], b, sa, rt));
    endtask

    // Reserved encodings define only the status pulses
    task automatic issueRaw(input logic [31:0] word);
        expectT e;
        e            = '0;
        e.func       = aluFuncT'(word[5:0]);
        e.illegal    = 1'b1;
        sendInstr(word, e);
    endtask

    task automatic finishTest(input string name, input int errorsBefore, input int checksBefore);
        int guard;
        guard = 0;
        @(negedge clk);
        instrValid = 1'b0;
        loadValid  = 1'b0;
        while ((pending.size() != 0) && (guard < 8))
        begin
            @(negedge clk);
            guard++;
        end
        if (pending.size() != 0)
        begin
            $display("Test %s: %0d results never came back", name, pending.size());
            errorCount++;
            pending.delete();
        end
        $display("Test %s finished: %0d results, %0d errors", name,
                 checkCount - checksBefore, errorCount - errorsBefore);
    endtask

    // --------------------
    // Collector samples on the falling edge where outputs are stable
    always @(negedge clk)
    begin : collect
        expectT e;
        if (!rst && resultValid)
        begin
            if (pending.size() == 0)
            begin
                $display("ERROR @ %0t: result reported with nothing outstanding", $time);
                errorCount++;
            end
            else
            begin
                e = pending.pop_front();
                checkCount++;
                checkFunc(e.func, {regWrite, trap, illegal}, {e.write, e.trap, e.illegal});
                if (e.checkValue)
                begin
                    checkWord({e.func.name(), " result"}, result, e.result);
                    checkFlags(e.func, {carry, zero, overflow, negative}, e.flags);
                end
                if (e.write)
                    checkWord("writeAddr", 32'(writeAddr), 32'(e.dest));
            end
        end
        else if (!rst && (regWrite || trap || illegal))
        begin
            $display("ERROR @ %0t: status pulse without resultValid", $time);
            errorCount++;
        end
    end

    // --------------------
    // Tests
    task automatic runArith();
        int      e0;
        int      c0;
        aluFuncT ops [4];
        e0  = errorCount;
        c0  = checkCount;
        ops = '{ADD, ADDU, SUB, SUBU};
        for (int r = 1; r <= 8; r++)
            loadReg(REG_ADDR_W'(r), $random(seed));
        loadReg(9, 32'h7fffffff);
        loadReg(10, 32'h00000001);
        loadReg(11, 32'h80000000);
        loadReg(12, 32'hffffffff);
        issueR(ADD, 9, 10, 13, 0);    // Overflow traps
        issueR(SUB, 11, 10, 13, 0);
        issueI(ADDI, 9, 14, 16'h0001);
        issueR(ADDU, 9, 10, 15, 0);   // Same sums without a trap
        issueR(ADDU, 12, 10, 16, 0);
        issueR(SUBU, 10, 12, 17, 0);
        issueI(ADDIU, 12, 18, 16'hffff);
        for (int i = 0; i < 12; i++)
        begin
            issueR(ops[$unsigned($random(seed)) % 4], pickReg(1, 8), pickReg(1, 8),
                   pickReg(1, 8), 0);
            issueI((i % 2 == 0) ? ADDI : ADDIU, pickReg(1, 8), pickReg(1, 8), 16'($random(seed)));
        end
        finishTest("arithmetic", e0, c0);
    endtask

    task automatic runLogic();
        int      e0;
        int      c0;
        aluFuncT ops [6];
        opcodeT  immOps [6];
        e0     = errorCount;
        c0     = checkCount;
        ops    = '{AND, OR, XOR, NOR, SLT, SLTU};
        immOps = '{ANDI, ORI, XORI, SLTI, SLTIU, LUI};
        for (int r = 1; r <= 6; r++)
            loadReg(REG_ADDR_W'(r), $random(seed));
        loadReg(7, 32'h80000000);
        loadReg(8, 32'h00000001);
        loadReg(9, 32'hffffffff);
        loadReg(10, 32'h00000000);
        issueR(SLT, 7, 8, 11, 0);     // Signed and unsigned disagree
        issueR(SLTU, 7, 8, 12, 0);
        issueR(SLT, 9, 10, 13, 0);
        issueR(SLTU, 9, 10, 14, 0);
        issueI(SLTI, 9, 15, 16'h0000);
        issueI(SLTIU, 8, 16, 16'hffff);
        issueI(LUI, 0, 17, 16'hbeef);
        for (int i = 0; i < 12; i++)
        begin
            issueR(ops[$unsigned($random(seed)) % 6], pickReg(1, 10), pickReg(1, 10),
                   pickReg(18, 8), 0);
            issueI(immOps[$unsigned($random(seed)) % 6], pickReg(1, 10), pickReg(18, 8),
                   16'($random(seed)));
        end
        finishTest("logic", e0, c0);
    endtask

    task automatic runShifts();
        int      e0;
        int      c0;
        aluFuncT ops [3];
        aluFuncT varOps [3];
        e0     = errorCount;
        c0     = checkCount;
        ops    = '{SLL, SRL, SRA};
        varOps = '{SLLV, SRLV, SRAV};
        for (int r = 1; r <= 4; r++)
            loadReg(REG_ADDR_W'(r), $random(seed) | 32'h80000000);
        loadReg(5, 32'h00000025);     // Amounts above 31
        loadReg(6, 32'hffffffe3);
        loadReg(7, 32'h00000040);
        for (int i = 0; i < 9; i++)
            issueR(ops[i % 3], 0, pickReg(1, 4), pickReg(8, 8), 5'($random(seed)));
        for (int i = 0; i < 9; i++)
            issueR(varOps[i % 3], REG_ADDR_W'(5 + i / 3), pickReg(1, 4), pickReg(8, 8), 0);
        finishTest("shifts", e0, c0);
    endtask

    task automatic runMoves();
        int e0;
        int c0;
        e0 = errorCount;
        c0 = checkCount;
        loadReg(1, $random(seed) | 32'h1);
        loadReg(2, 32'h00000000);
        loadReg(3, 32'h00001234);
        issueR(MOVZ, 1, 2, 4, 0);     // Writes since rt is zero
        issueR(MOVZ, 1, 3, 5, 0);     // Blocked
        issueR(MOVN, 1, 3, 6, 0);
        issueR(MOVN, 1, 2, 7, 0);     // Blocked
        issueR(ADDU, 5, 0, 9, 0);     // Old value survives
        issueR(ADDU, 7, 0, 10, 0);
        issueR(ADDU, 1, 3, 0, 0);     // Pipeline write to r0
        loadReg(0, 32'hdeadbeef);
        issueR(ADDU, 0, 0, 8, 0);
        finishTest("moves", e0, c0);
    endtask

    task automatic runChains();
        int e0;
        int c0;
        e0 = errorCount;
        c0 = checkCount;
        loadReg(1, 32'h00000005);
        loadReg(2, $random(seed));
        issueR(ADDU, 1, 2, 3, 0);     // Each reads the previous result
        issueR(SUBU, 3, 1, 4, 0);
        issueR(XOR, 4, 3, 5, 0);
        issueR(SLL, 0, 5, 6, 3);
        issueI(ADDIU, 6, 7, 16'h8001);
        issueR(OR, 7, 3, 3, 0);
        issueR(ADDU, 3, 7, 8, 0);
        issueRaw({6'h01, 5'd1, 5'd9, 16'h1234});    // REGIMM
        issueRaw({6'h23, 5'd1, 5'd9, 16'h0004});    // LW
        issueRaw({6'h00, 5'd1, 5'd2, 5'd10, 5'd0, 6'h18});   // MULT
        issueRaw({6'h00, 5'd1, 5'd0, 5'd10, 5'd0, 6'h08});   // JR
        issueR(ADDU, 9, 0, 11, 0);
        issueR(ADDU, 10, 0, 12, 0);
        finishTest("chains", e0, c0);
    endtask

    // --------------------
    // Main sequence
    initial
    begin
        instrValid = 1'b0;
        instr      = '0;
        loadValid  = 1'b0;
        loadAddr   = '0;
        loadData   = '0;
        rst        = 1'b1;
        for (int i = 0; i < 32; i++)
            model[i] = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        runArith();
        runLogic();
        runShifts();
        runMoves();
        runChains();
        $display("Summary: %0d results checked, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // Budget grows with every driven cycle
    initial
    begin : watchdog
        while ($time <= time'(stepCount) * 4 + 200)
            @(posedge clk);
        $display("Timeout at %0t: run took longer than %0d driven cycles allow", $time, stepCount);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- hw/mipsExecCore.sv
// Top level of the execute core connecting decoder, register file and execute pipeline
`timescale 1ns/1ps

module mipsExecCore
    import mipsPkg::*;
#(
    parameter bit RESET_ZERO = 1'b1   // Clear registers on reset
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instrValid,
    input  logic [31:0]           instr,
    input  logic                  loadValid,
    input  logic [REG_ADDR_W-1:0] loadAddr,
    input  logic [31:0]           loadData,
    output logic                  resultValid,
    output logic [31:0]           result,
    output logic                  carry,
    output logic                  zero,
    output logic                  overflow,
    output logic                  negative,
    output logic                  regWrite,
    output logic [REG_ADDR_W-1:0] writeAddr,
    output logic                  trap,
    output logic                  illegal
);

    logic [REG_ADDR_W-1:0] rsAddr;
    logic [REG_ADDR_W-1:0] rtAddr;
    logic [REG_ADDR_W-1:0] destAddr;
    logic [REG_ADDR_W-1:0] shamt;
    aluFuncT               func;
    logic [31:0]           immValue;
    logic                  useImm;
    logic                  checkOverflow;
    logic                  reserved;
    logic [31:0]           rsData;
    logic [31:0]           rtData;
    logic                  wbEnable;
    logic [REG_ADDR_W-1:0] wbAddr;
    logic [31:0]           wbData;

    instrDecode i_instrDecode (
        .instr         (instr),
        .rsAddr        (rsAddr),
        .rtAddr        (rtAddr),
        .destAddr      (destAddr),
        .func          (func),
        .immValue      (immValue),
        .useImm        (useImm),
        .checkOverflow (checkOverflow),
        .reserved      (reserved),
        .shamt         (shamt)
    );

    regFile #(
        .RESET_ZERO (RESET_ZERO)
    ) i_regFile (
        .clk       (clk),
        .rst       (rst),
        .rsAddr    (rsAddr),
        .rtAddr    (rtAddr),
        .wbEnable  (wbEnable),
        .wbAddr    (wbAddr),
        .wbData    (wbData),
        .loadValid (loadValid),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .rsData    (rsData),
        .rtData    (rtData)
    );

    execStage i_execStage (
        .clk           (clk),
        .rst           (rst),
        .instrValid    (instrValid),
        .func          (func),
        .rsData        (rsData),
        .rtData        (rtData),
        .immValue      (immValue),
        .useImm        (useImm),
        .shamt         (shamt),
        .destAddr      (destAddr),
        .checkOverflow (checkOverflow),
        .reserved      (reserved),
        .wbEnable      (wbEnable),
        .wbAddr        (wbAddr),
        .wbData        (wbData),
        .resultValid   (resultValid),
        .result        (result),
        .carry         (carry),
        .zero          (zero),
        .overflow      (overflow),
        .negative      (negative),
        .regWrite      (regWrite),
        .writeAddr     (writeAddr),
        .trap          (trap),
        .illegal       (illegal)
    );

endmodule

//--- hw/execStage.sv
// Two-stage execute pipeline that captures operands, runs the ALU and decides writeback
`timescale 1ns/1ps

module execStage
    import mipsPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instrValid,
    input  aluFuncT               func,
    input  logic [31:0]           rsData,
    input  logic [31:0]           rtData,
    input  logic [31:0]           immValue,
    input  logic                  useImm,
    input  logic [REG_ADDR_W-1:0] shamt,
    input  logic [REG_ADDR_W-1:0] destAddr,
    input  logic                  checkOverflow,
    input  logic                  reserved,
    output logic                  wbEnable,
    output logic [REG_ADDR_W-1:0] wbAddr,
    output logic [31:0]           wbData,
    output logic                  resultValid,
    output logic [31:0]           result,
    output logic                  carry,
    output logic                  zero,
    output logic                  overflow,
    output logic                  negative,
    output logic                  regWrite,
    output logic [REG_ADDR_W-1:0] writeAddr,
    output logic                  trap,
    output logic                  illegal
);

    logic                  s1Valid;
    aluFuncT               s1Func;
    logic [31:0]           s1A;
    logic [31:0]           s1B;
    logic [REG_ADDR_W-1:0] s1Shamt;
    logic [REG_ADDR_W-1:0] s1Dest;
    logic                  s1CheckOvf;
    logic                  s1Reserved;
    logic [31:0]           aluOut;
    logic                  aluCarry;
    logic                  aluZero;
    logic                  aluOverflow;
    logic                  aluNegative;
    logic                  ovfTrap;
    logic                  moveBlocked;
    logic [32:0]           wideRes;

    // --------------------
    // Stage 1 capture
    always_ff @(posedge clk)
    begin
        if (rst)
            s1Valid <= 1'b0;
        else
            s1Valid <= instrValid;
    end

    always_ff @(posedge clk)
    begin
        if (instrValid)
        begin
            s1Func     <= func;
            s1A        <= rsData;
            s1B        <= useImm ? immValue : rtData;
            s1Shamt    <= shamt;
            s1Dest     <= destAddr;
            s1CheckOvf <= checkOverflow;
            s1Reserved <= reserved;
        end
    end

    alu i_alu (
        .a        (s1A),
        .b        (s1B),
        .shamt    (s1Shamt),
        .func     (s1Func),
        .out      (aluOut),
        .carry    (aluCarry),
        .zero     (aluZero),
        .overflow (aluOverflow),
        .negative (aluNegative)
    );

    // --------------------
    // Stage 2 writeback decision
    assign ovfTrap     = s1CheckOvf && aluOverflow && !s1Reserved;
    // s1B holds rt for both moves
    assign moveBlocked = ((s1Func == MOVZ) && (s1B != '0)) ||
                         ((s1Func == MOVN) && (s1B == '0));

    assign wbEnable = s1Valid && !s1Reserved && !ovfTrap && !moveBlocked && (s1Dest != '0);
    assign wbAddr   = s1Dest;
    assign wbData   = aluOut;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            resultValid <= 1'b0;
            regWrite    <= 1'b0;
            trap        <= 1'b0;
            illegal     <= 1'b0;
        end
        else
        begin
            resultValid <= s1Valid;   // One-cycle pulse per instruction
            regWrite    <= wbEnable;
            trap        <= s1Valid && ovfTrap;
            illegal     <= s1Valid && s1Reserved;
        end
    end

    always_ff @(posedge clk)
    begin
        if (s1Valid)
        begin
            result    <= aluOut;
            carry     <= aluCarry;
            zero      <= aluZero;
            overflow  <= aluOverflow;
            negative  <= aluNegative;
            writeAddr <= s1Dest;
        end
    end

    // Sign-extended 33-bit result, top two bits differ on signed overflow
    assign wideRes = (s1Func == SUB) ? ({s1A[31], s1A} - {s1B[31], s1B})
                                     : ({s1A[31], s1A} + {s1B[31], s1B});

    trapIsSignedOvf: assert property (@(posedge clk) disable iff (rst)
        (s1Valid && ovfTrap) |-> (wideRes[32] != wideRes[31]))
        else $error("trap raised without signed overflow");

endmodule

//--- hw/regFile.sv
// Register file with two combinational read ports, pipeline writeback and an external load port
`timescale 1ns/1ps

module regFile
    import mipsPkg::*;
#(
    parameter bit RESET_ZERO = 1'b1
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] rsAddr,
    input  logic [REG_ADDR_W-1:0] rtAddr,
    input  logic                  wbEnable,
    input  logic [REG_ADDR_W-1:0] wbAddr,
    input  logic [31:0]           wbData,
    input  logic                  loadValid,
    input  logic [REG_ADDR_W-1:0] loadAddr,
    input  logic [31:0]           loadData,
    output logic [31:0]           rsData,
    output logic [31:0]           rtData
);

    logic [31:0] regs [1:31];   // r0 has no storage

    function automatic logic [31:0] readPort(input logic [REG_ADDR_W-1:0] addr);
        logic [31:0] value;
        if (addr == '0)
            value = '0;
        else if (wbEnable && (wbAddr == addr))
            value = wbData;   // Same-edge writeback seen by the next instruction
        else
            value = regs[addr];
        return value;
    endfunction

    always_comb
    begin
        rsData = readPort(rsAddr);
        rtData = readPort(rtAddr);
    end

    always_ff @(posedge clk)
    begin
        if (rst && RESET_ZERO)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else
        begin
            if (loadValid && (loadAddr != '0))
                regs[loadAddr] <= loadData;
            // Later assignment wins, so the pipeline port takes a collision
            if (wbEnable && (wbAddr != '0))
                regs[wbAddr] <= wbData;
        end
    end

    // A load without a pipeline collision reads back on the next cycle
    loadReadBack: assert property (@(posedge clk) disable iff (rst)
        (loadValid && (loadAddr != '0) && !(wbEnable && (wbAddr == loadAddr)))
            |=> ((rsAddr != $past(loadAddr)) || (wbEnable && (wbAddr == rsAddr)) ||
                 (rsData == $past(loadData))))
        else $error("loaded register did not read back its value");

endmodule

//--- hw/instrDecode.sv
// Instruction decoder giving register indices, ALU function and operand controls to the core
`timescale 1ns/1ps

module instrDecode
    import mipsPkg::*;
(
    input  logic [31:0]           instr,
    output logic [REG_ADDR_W-1:0] rsAddr,
    output logic [REG_ADDR_W-1:0] rtAddr,
    output logic [REG_ADDR_W-1:0] destAddr,
    output aluFuncT               func,
    output logic [31:0]           immValue,
    output logic                  useImm,
    output logic                  checkOverflow,
    output logic                  reserved,
    output logic [REG_ADDR_W-1:0] shamt
);

    opcodeT                opcode;
    logic [5:0]            functField;
    logic [REG_ADDR_W-1:0] rdField;
    logic [15:0]           imm;

    assign opcode     = opcodeT'(instr[31:26]);
    assign rsAddr     = instr[25:21];
    assign rtAddr     = instr[20:16];
    assign rdField    = instr[15:11];
    assign functField = instr[5:0];
    assign imm        = instr[15:0];

    always_comb
    begin
        func          = ADDU;
        immValue      = {{16{imm[15]}}, imm};   // Sign-extended unless overridden
        useImm        = 1'b1;
        checkOverflow = 1'b0;
        reserved      = 1'b0;
        destAddr      = rtAddr;                 // Immediate group writes rt
        shamt         = '0;

        case (opcode)
            SPECIAL:
            begin
                useImm   = 1'b0;
                destAddr = rdField;
                shamt    = instr[10:6];
                case (functField)
                    ADD, SUB:
                    begin
                        func          = aluFuncT'(functField);
                        checkOverflow = 1'b1;
                    end
                    ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
                    SLL, SRL, SRA, SLLV, SRLV, SRAV, MOVZ, MOVN:
                        func = aluFuncT'(functField);
                    default:
                        reserved = 1'b1;
                endcase
            end
            ADDI:
            begin
                func          = ADD;
                checkOverflow = 1'b1;
            end
            ADDIU: func = ADDU;
            SLTI:  func = SLT;
            SLTIU: func = SLTU;   // Sign-extended, then compared unsigned
            ANDI:
            begin
                func     = AND;
                immValue = {16'b0, imm};
            end
            ORI:
            begin
                func     = OR;
                immValue = {16'b0, imm};
            end
            XORI:
            begin
                func     = XOR;
                immValue = {16'b0, imm};
            end
            LUI:
            begin
                func     = SLL;   // Immediate shifted into the upper half
                immValue = {16'b0, imm};
                shamt    = 5'd16;
            end
            default: reserved = 1'b1;
        endcase
    end

endmodule

//--- hw/alu.sv
// Combinational ALU used by the execute stage to produce a result and four flags per function
`timescale 1ns/1ps

module alu
    import mipsPkg::*;
(
    input  logic [31:0]           a,
    input  logic [31:0]           b,
    input  logic [REG_ADDR_W-1:0] shamt,
    input  aluFuncT               func,
    output logic [31:0]           out,
    output logic                  carry,
    output logic                  zero,
    output logic                  overflow,
    output logic                  negative
);

    logic [32:0]           sum;
    logic [32:0]           diff;
    logic [REG_ADDR_W-1:0] varAmt;
    logic                  addOvf;
    logic                  subOvf;

    assign sum    = {1'b0, a} + {1'b0, b};
    assign diff   = {1'b0, a} - {1'b0, b};   // Bit 32 is the borrow
    assign varAmt = a[REG_ADDR_W-1:0];        // Variable shifts use low bits only

    // Operands of equal sign giving a result of the other sign
    assign addOvf = (a[31] == b[31]) && (sum[31] != a[31]);
    // Subtract adds ~b, so the signs must differ here
    assign subOvf = (a[31] != b[31]) && (diff[31] != a[31]);

    assign negative = out[31];
    assign zero     = (out == '0);

    always_comb
    begin
        out      = '0;
        carry    = 1'b0;
        overflow = 1'b0;

        case (func)
            // --------------------
            // Add and subtract
            ADD:
            begin
                out      = sum[31:0];
                carry    = sum[32];
                overflow = addOvf;
            end
            ADDU:
            begin
                out      = sum[31:0];
                carry    = sum[32];
                overflow = sum[32];   // Unsigned forms report carry here
            end
            SUB:
            begin
                out      = diff[31:0];
                carry    = diff[32];
                overflow = subOvf;
            end
            SUBU:
            begin
                out      = diff[31:0];
                carry    = diff[32];
                overflow = diff[32];
            end

            // --------------------
            // Shifts of operand b
            SLL:  out = b << shamt;
            SRL:  out = b >> shamt;
            SRA:  out = $signed(b) >>> shamt;
            SLLV: out = b << varAmt;
            SRLV: out = b >> varAmt;
            SRAV: out = $signed(b) >>> varAmt;

            // Logic
            AND:  out = a & b;
            OR:   out = a | b;
            XOR:  out = a ^ b;
            NOR:  out = ~(a | b);

            // Set on less than
            SLT:  out = {31'b0, $signed(a) < $signed(b)};
            SLTU: out = {31'b0, a < b};

            // Write condition is decided in the execute stage
            MOVZ,
            MOVN: out = a;

            default: out = '0;
        endcase
    end

endmodule

//--- hw/mipsPkg.sv
// Shared ALU function codes, primary opcodes and register index width imported by the core
package mipsPkg;

    localparam int REG_ADDR_W = 5;  // 32 architectural registers

    // --------------------
    // ALU functions

    // Values match the funct field of SPECIAL so R-type decode is a straight cast
    typedef enum logic [5:0] {
        SLL  = 6'h00,
        SRL  = 6'h02,
        SRA  = 6'h03,
        SLLV = 6'h04,
        SRLV = 6'h06,
        SRAV = 6'h07,
        MOVZ = 6'h0A,   // Write rs if rt == 0
        MOVN = 6'h0B,   // Write rs if rt != 0
        ADD  = 6'h20,   // Traps on signed overflow
        ADDU = 6'h21,
        SUB  = 6'h22,   // Traps on signed overflow
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        NOR  = 6'h27,
        SLT  = 6'h2A,
        SLTU = 6'h2B
    } aluFuncT;

    // --------------------
    // Primary opcodes

    // Only SPECIAL and the immediate arithmetic/logic group
    typedef enum logic [5:0] {
        SPECIAL = 6'h00,
        ADDI    = 6'h08,
        ADDIU   = 6'h09,
        SLTI    = 6'h0A,
        SLTIU   = 6'h0B,
        ANDI    = 6'h0C,   // Zero-extended immediate
        ORI     = 6'h0D,   // Zero-extended immediate
        XORI    = 6'h0E,   // Zero-extended immediate
        LUI     = 6'h0F
    } opcodeT;

endpackage
